//--- src/lane_buf_pkg.sv
package lane_buf_pkg;

  // datapath word width shared by every lane
  localparam int DATA_W = 32;

  // apb address bus width
  localparam int APB_AW = 4;

  typedef logic [DATA_W-1:0] lane_data_t;

  // how the lane FIFOs are wired together
  // k3 gives independent lanes, k5 pairs lane j with lane j+half,
  // chain strings every lane behind port 0
  typedef enum logic [1:0] {
    MODE_K3    = 2'd0,
    MODE_K5    = 2'd1,
    MODE_CHAIN = 2'd2
  } k_mode_t;

  // register map of the apb slave
  typedef enum logic [3:0] {
    REG_KSIZE  = 4'h0,
    REG_STATUS = 4'h4
  } reg_addr_t;

endpackage

//--- src/lane_fifo.sv
module lane_fifo #(
  parameter int DATA_W     = lane_buf_pkg::DATA_W,
  parameter int LANE_DEPTH = 4
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    in_vld,
  output logic                    in_rdy,
  input  lane_buf_pkg::lane_data_t in_data,
  output logic                    out_vld,
  input  logic                    out_rdy,
  output lane_buf_pkg::lane_data_t out_data,
  output logic                    empty
);

  localparam int PTR_W = $clog2(LANE_DEPTH);
  localparam int CNT_W = $clog2(LANE_DEPTH + 1);

  // storage, no reset needed
  logic [DATA_W-1:0] mem [LANE_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  logic push;
  logic pop;

  // flags come from count only, so a chain of lanes has no
  // combinational ready path running through it
  assign in_rdy   = (count != CNT_W'(LANE_DEPTH));
  assign out_vld  = (count != '0);
  assign empty    = (count == '0);
  assign out_data = mem[rd_ptr];

  assign push = in_vld & in_rdy;
  assign pop  = out_vld & out_rdy;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // pointers wrap naturally, depth is a power of two
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  a_count_bound: assert property (@(posedge clk) disable iff (reset)
    count <= CNT_W'(LANE_DEPTH))
    else $error("lane_fifo: occupancy above depth");

  // a stalled head word must not move under the consumer
  a_hold_data: assert property (@(posedge clk) disable iff (reset)
    out_vld && !out_rdy |=> $stable(out_data))
    else $error("lane_fifo: output data changed while stalled");

endmodule

//--- src/lane_router.sv
module lane_router #(
  parameter int NUM_LANES = 8
) (
  input  lane_buf_pkg::k_mode_t    k_mode,
  // external side
  input  logic [NUM_LANES-1:0]     in_vld,
  output logic [NUM_LANES-1:0]     in_rdy,
  input  lane_buf_pkg::lane_data_t in_data [NUM_LANES],
  output logic [NUM_LANES-1:0]     out_vld,
  input  logic [NUM_LANES-1:0]     out_rdy,
  output lane_buf_pkg::lane_data_t out_data [NUM_LANES],
  // fifo side
  output logic [NUM_LANES-1:0]     lane_in_vld,
  input  logic [NUM_LANES-1:0]     lane_in_rdy,
  output lane_buf_pkg::lane_data_t lane_in_data [NUM_LANES],
  input  logic [NUM_LANES-1:0]     lane_out_vld,
  output logic [NUM_LANES-1:0]     lane_out_rdy,
  input  lane_buf_pkg::lane_data_t lane_out_data [NUM_LANES]
);

  localparam int HALF = NUM_LANES / 2;

  // external ports that carry a stream in the current mode
  logic [NUM_LANES-1:0] port_used;

  always_comb begin
    // unused ports and links stay at zero
    in_rdy       = '0;
    out_vld      = '0;
    lane_in_vld  = '0;
    lane_out_rdy = '0;
    for (int j = 0; j < NUM_LANES; j++) begin
      out_data[j]     = '0;
      lane_in_data[j] = '0;
    end

    case (k_mode)
      lane_buf_pkg::MODE_K3: begin
        for (int j = 0; j < NUM_LANES; j++) begin
          lane_in_vld[j]  = in_vld[j];
          lane_in_data[j] = in_data[j];
          in_rdy[j]       = lane_in_rdy[j];
          out_vld[j]      = lane_out_vld[j];
          out_data[j]     = lane_out_data[j];
          lane_out_rdy[j] = out_rdy[j];
        end
      end

      lane_buf_pkg::MODE_K5: begin
        for (int j = 0; j < HALF; j++) begin
          // input enters the upper lane of the pair
          lane_in_vld[j+HALF]  = in_vld[j];
          lane_in_data[j+HALF] = in_data[j];
          in_rdy[j]            = lane_in_rdy[j+HALF];
          // upper lane drains into the lower lane
          lane_in_vld[j]       = lane_out_vld[j+HALF];
          lane_in_data[j]      = lane_out_data[j+HALF];
          lane_out_rdy[j+HALF] = lane_in_rdy[j];
          // lower lane drives the port
          out_vld[j]           = lane_out_vld[j];
          out_data[j]          = lane_out_data[j];
          lane_out_rdy[j]      = out_rdy[j];
        end
      end

      default: begin
        // port 0 feeds the top lane, words walk down to lane 0
        lane_in_vld[NUM_LANES-1]  = in_vld[0];
        lane_in_data[NUM_LANES-1] = in_data[0];
        in_rdy[0]                 = lane_in_rdy[NUM_LANES-1];
        for (int j = 0; j < NUM_LANES - 1; j++) begin
          lane_in_vld[j]    = lane_out_vld[j+1];
          lane_in_data[j]   = lane_out_data[j+1];
          lane_out_rdy[j+1] = lane_in_rdy[j];
        end
        out_vld[0]      = lane_out_vld[0];
        out_data[0]     = lane_out_data[0];
        lane_out_rdy[0] = out_rdy[0];
      end
    endcase
  end

  // k5 serves the lower half of the ports, the chain only port 0
  always_comb begin
    case (k_mode)
      lane_buf_pkg::MODE_K3: port_used = '1;
      lane_buf_pkg::MODE_K5: port_used = {{HALF{1'b0}}, {HALF{1'b1}}};
      default:               port_used = NUM_LANES'(1);
    endcase
  end

  // no clock here, so the check runs on every change
  always_comb begin
    a_unused_quiet: assert ((out_vld & ~port_used) == '0)
      else $error("lane_router: valid on a port unused in this mode");
  end

endmodule

//--- src/kernel_cfg_apb.sv
module kernel_cfg_apb #(
  parameter int NUM_LANES = 8
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            psel,
  input  logic                            penable,
  input  logic                            pwrite,
  input  logic [lane_buf_pkg::APB_AW-1:0] paddr,
  input  logic [31:0]                     pwdata,
  output logic [31:0]                     prdata,
  output logic                            pready,
  output logic                            pslverr,
  input  logic [NUM_LANES-1:0]            lane_empty,
  output lane_buf_pkg::k_mode_t           k_mode
);

  logic                  access;
  logic                  addr_ok;
  logic                  all_empty;
  logic                  ksize_wr;
  logic [3:0]            ksize_rd;
  lane_buf_pkg::k_mode_t wr_mode;

  // zero wait states
  assign pready = 1'b1;

  assign access    = psel & penable;
  assign all_empty = &lane_empty;
  assign addr_ok   = (paddr == lane_buf_pkg::REG_KSIZE) ||
                     (paddr == lane_buf_pkg::REG_STATUS);
  assign ksize_wr  = access & pwrite & (paddr == lane_buf_pkg::REG_KSIZE);

  // rewiring with words in flight would scramble the streams
  assign pslverr = access & (!addr_ok | (ksize_wr & !all_empty));

  always_comb begin
    case (pwdata[3:0])
      4'd3:    wr_mode = lane_buf_pkg::MODE_K3;
      4'd5:    wr_mode = lane_buf_pkg::MODE_K5;
      default: wr_mode = lane_buf_pkg::MODE_CHAIN;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      k_mode <= lane_buf_pkg::MODE_K3;
    end else if (ksize_wr && all_empty) begin
      k_mode <= wr_mode;
    end
  end

  // chain mode reads back as kernel size 7
  always_comb begin
    case (k_mode)
      lane_buf_pkg::MODE_K3: ksize_rd = 4'd3;
      lane_buf_pkg::MODE_K5: ksize_rd = 4'd5;
      default:               ksize_rd = 4'd7;
    endcase
  end

  always_comb begin
    case (lane_buf_pkg::reg_addr_t'(paddr))
      lane_buf_pkg::REG_KSIZE:  prdata = {28'd0, ksize_rd};
      lane_buf_pkg::REG_STATUS: prdata = 32'(lane_empty);
      default:                  prdata = '0;
    endcase
  end

  // empty flags come from the lane FIFOs
  a_mode_frozen: assert property (@(posedge clk) disable iff (reset)
    !all_empty |=> $stable(k_mode))
    else $error("kernel_cfg_apb: mode changed with data in a lane");

endmodule

//--- src/output_lane_bank.sv
module output_lane_bank #(
  parameter int NUM_LANES  = 8,
  parameter int LANE_DEPTH = 4
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [NUM_LANES-1:0]            in_vld,
  output logic [NUM_LANES-1:0]            in_rdy,
  input  lane_buf_pkg::lane_data_t        in_data [NUM_LANES],
  output logic [NUM_LANES-1:0]            out_vld,
  input  logic [NUM_LANES-1:0]            out_rdy,
  output lane_buf_pkg::lane_data_t        out_data [NUM_LANES],
  input  logic                            psel,
  input  logic                            penable,
  input  logic                            pwrite,
  input  logic [lane_buf_pkg::APB_AW-1:0] paddr,
  input  logic [31:0]                     pwdata,
  output logic [31:0]                     prdata,
  output logic                            pready,
  output logic                            pslverr
);

  lane_buf_pkg::k_mode_t    k_mode;
  logic [NUM_LANES-1:0]     lane_empty;

  // router to fifo links
  logic [NUM_LANES-1:0]     lane_in_vld;
  logic [NUM_LANES-1:0]     lane_in_rdy;
  lane_buf_pkg::lane_data_t lane_in_data [NUM_LANES];
  logic [NUM_LANES-1:0]     lane_out_vld;
  logic [NUM_LANES-1:0]     lane_out_rdy;
  lane_buf_pkg::lane_data_t lane_out_data [NUM_LANES];

  kernel_cfg_apb #(
    .NUM_LANES (NUM_LANES)
  ) u_cfg (
    .clk        (clk),
    .reset      (reset),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .lane_empty (lane_empty),
    .k_mode     (k_mode)
  );

  lane_router #(
    .NUM_LANES (NUM_LANES)
  ) u_router (
    .k_mode        (k_mode),
    .in_vld        (in_vld),
    .in_rdy        (in_rdy),
    .in_data       (in_data),
    .out_vld       (out_vld),
    .out_rdy       (out_rdy),
    .out_data      (out_data),
    .lane_in_vld   (lane_in_vld),
    .lane_in_rdy   (lane_in_rdy),
    .lane_in_data  (lane_in_data),
    .lane_out_vld  (lane_out_vld),
    .lane_out_rdy  (lane_out_rdy),
    .lane_out_data (lane_out_data)
  );

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    lane_fifo #(
      .DATA_W     (lane_buf_pkg::DATA_W),
      .LANE_DEPTH (LANE_DEPTH)
    ) u_fifo (
      .clk      (clk),
      .reset    (reset),
      .in_vld   (lane_in_vld[i]),
      .in_rdy   (lane_in_rdy[i]),
      .in_data  (lane_in_data[i]),
      .out_vld  (lane_out_vld[i]),
      .out_rdy  (lane_out_rdy[i]),
      .out_data (lane_out_data[i]),
      .empty    (lane_empty[i])
    );
  end

endmodule

//--- bench/tb_clock.sv
module tb_clock #(
  parameter int PERIOD_NS = 10
) (
  output logic clk
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
  end

  // first rising edge half a period in
  always begin
    #(PERIOD_NS / 2) clk = ~clk;
  end

endmodule

//--- bench/output_lane_bank_tb.sv
module output_lane_bank_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_LANES  = 8;
  localparam int LANE_DEPTH = 4;
  localparam int TIMEOUT    = 2000;

  logic                            clk;
  logic                            reset;
  logic [NUM_LANES-1:0]            in_vld;
  logic [NUM_LANES-1:0]            in_rdy;
  lane_buf_pkg::lane_data_t        in_data [NUM_LANES];
  logic [NUM_LANES-1:0]            out_vld;
  logic [NUM_LANES-1:0]            out_rdy;
  lane_buf_pkg::lane_data_t        out_data [NUM_LANES];
  logic                            psel;
  logic                            penable;
  logic                            pwrite;
  logic [lane_buf_pkg::APB_AW-1:0] paddr;
  logic [31:0]                     pwdata;
  logic [31:0]                     prdata;
  logic                            pready;
  logic                            pslverr;

  int seed;
  // one expected stream per port, input j always comes out on output j
  lane_buf_pkg::lane_data_t model_q [NUM_LANES][$];

  tb_clock u_clock (.clk(clk));

  output_lane_bank #(
    .NUM_LANES  (NUM_LANES),
    .LANE_DEPTH (LANE_DEPTH)
  ) dut (
    .clk      (clk),
    .reset    (reset),
    .in_vld   (in_vld),
    .in_rdy   (in_rdy),
    .in_data  (in_data),
    .out_vld  (out_vld),
    .out_rdy  (out_rdy),
    .out_data (out_data),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr)
  );

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_data(input string name, input int lane,
                            input lane_buf_pkg::lane_data_t exp,
                            input lane_buf_pkg::lane_data_t act);
    if (exp !== act) begin
      stop_run($sformatf("FAIL %s lane %0d: expected %h actual %h", name, lane, exp, act));
    end
  endtask

  task automatic check_mode(input string name, input lane_buf_pkg::k_mode_t exp,
                            input lane_buf_pkg::k_mode_t act);
    if (exp !== act) begin
      stop_run($sformatf("FAIL %s: expected mode %0d actual mode %0d", name, exp, act));
    end
  endtask

  task automatic check_bits(input string name, input logic [31:0] exp,
                            input logic [31:0] act);
    if (exp !== act) begin
      stop_run($sformatf("FAIL %s: expected %h actual %h", name, exp, act));
    end
  endtask

  function automatic logic [31:0] next_rand();
    next_rand = $random(seed);
  endfunction

  // ports that carry a stream in each mode
  function automatic logic [NUM_LANES-1:0] active_ports(input lane_buf_pkg::k_mode_t m);
    case (m)
      lane_buf_pkg::MODE_K3: active_ports = '1;
      lane_buf_pkg::MODE_K5: active_ports = {{(NUM_LANES/2){1'b0}}, {(NUM_LANES/2){1'b1}}};
      default:               active_ports = NUM_LANES'(1);
    endcase
  endfunction

  function automatic lane_buf_pkg::k_mode_t decode_ksize(input logic [31:0] d);
    case (d)
      32'd3:   decode_ksize = lane_buf_pkg::MODE_K3;
      32'd5:   decode_ksize = lane_buf_pkg::MODE_K5;
      32'd7:   decode_ksize = lane_buf_pkg::MODE_CHAIN;
      default: decode_ksize = lane_buf_pkg::k_mode_t'(2'd3);
    endcase
  endfunction

  // setup and access phase, sampled 1 ns before the closing edge
  task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    int waits;
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    waits   = 0;
    #4;
    while (!pready) begin
      waits++;
      if (waits > 16) stop_run("APB transfer never completed, pready stayed low");
      @(negedge clk);
      #4;
    end
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic write_ksize(input string name, input logic [31:0] data, input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_xfer(1'b1, lane_buf_pkg::REG_KSIZE, data, rdata, err);
    check_bits(name, {31'd0, exp_err}, {31'd0, err});
  endtask

  task automatic check_ksize(input string name, input lane_buf_pkg::k_mode_t exp);
    logic [31:0] rdata;
    logic        err;
    apb_xfer(1'b0, lane_buf_pkg::REG_KSIZE, 32'd0, rdata, err);
    check_bits({name, "_err"}, 32'd0, {31'd0, err});
    check_mode(name, exp, decode_ksize(rdata));
  endtask

  task automatic check_status(input string name, input logic [31:0] exp);
    logic [31:0] rdata;
    logic        err;
    apb_xfer(1'b0, lane_buf_pkg::REG_STATUS, 32'd0, rdata, err);
    check_bits({name, "_err"}, 32'd0, {31'd0, err});
    check_bits(name, exp, rdata);
  endtask

  // random traffic on the active ports until every stream has drained
  task automatic run_traffic(input string name, input logic [NUM_LANES-1:0] active,
                             input int nwords);
    int                       sent [NUM_LANES];
    int                       cycles;
    logic                     busy;
    logic [31:0]              r;
    logic [NUM_LANES-1:0]     taken;
    lane_buf_pkg::lane_data_t exp;
    for (int j = 0; j < NUM_LANES; j++) begin
      sent[j] = 0;
    end
    taken  = '0;
    cycles = 0;
    busy   = 1'b1;
    while (busy) begin
      cycles++;
      if (cycles > TIMEOUT) stop_run($sformatf("%s: streams did not drain in time", name));
      @(negedge clk);
      for (int j = 0; j < NUM_LANES; j++) begin
        r = next_rand();
        out_rdy[j] = active[j] & r[0];
        if (taken[j]) begin
          in_vld[j] = 1'b0;
        end
        if (!in_vld[j] && active[j] && sent[j] < nwords && r[1]) begin
          in_vld[j]  = 1'b1;
          in_data[j] = next_rand();
        end
      end
      #4;
      busy = 1'b0;
      for (int j = 0; j < NUM_LANES; j++) begin
        if (!active[j] && (in_rdy[j] || out_vld[j])) begin
          stop_run($sformatf("%s: unused port %0d shows in_rdy or out_vld high", name, j));
        end
        if (!active[j]) begin
          check_data({name, "_unused"}, j, '0, out_data[j]);
        end
        taken[j] = in_vld[j] & in_rdy[j];
        if (taken[j]) begin
          model_q[j].push_back(in_data[j]);
          sent[j]++;
        end
        if (out_vld[j] && out_rdy[j]) begin
          if (model_q[j].size() == 0) begin
            stop_run($sformatf("%s: port %0d delivered a word never sent", name, j));
          end
          exp = model_q[j].pop_front();
          check_data(name, j, exp, out_data[j]);
        end
        if (active[j] && (sent[j] < nwords || model_q[j].size() != 0)) begin
          busy = 1'b1;
        end
      end
    end
    @(negedge clk);
    in_vld  = '0;
    out_rdy = '0;
  endtask

  // one word into a lane while its output is held off
  task automatic load_word(input int lane, input lane_buf_pkg::lane_data_t data);
    int cycles;
    @(negedge clk);
    in_vld[lane]  = 1'b1;
    in_data[lane] = data;
    cycles = 0;
    #4;
    while (!in_rdy[lane]) begin
      cycles++;
      if (cycles > TIMEOUT) stop_run($sformatf("lane %0d never accepted a word", lane));
      @(negedge clk);
      #4;
    end
    model_q[lane].push_back(data);
    @(negedge clk);
    in_vld[lane] = 1'b0;
  endtask

  initial begin
    logic [31:0] rdata;
    logic        err;
    logic [31:0] all_empty;
    logic [31:0] held;
    seed    = 32'h811e_34cd;
    reset   = 1'b1;
    in_vld  = '0;
    out_rdy = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    for (int j = 0; j < NUM_LANES; j++) begin
      in_data[j] = '0;
    end
    all_empty = {{(32-NUM_LANES){1'b0}}, {NUM_LANES{1'b1}}};
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    check_ksize("reset_ksize", lane_buf_pkg::MODE_K3);
    check_status("reset_status", all_empty);
    apb_xfer(1'b0, 4'h8, 32'd0, rdata, err);
    check_bits("unmapped_err", 32'd1, {31'd0, err});

    run_traffic("k3_traffic", active_ports(lane_buf_pkg::MODE_K3), 24);

    write_ksize("write_k5", 32'd5, 1'b0);
    check_ksize("read_k5", lane_buf_pkg::MODE_K5);
    run_traffic("k5_traffic", active_ports(lane_buf_pkg::MODE_K5), 24);

    write_ksize("write_chain", 32'd7, 1'b0);
    check_ksize("read_chain", lane_buf_pkg::MODE_CHAIN);
    run_traffic("chain_traffic", active_ports(lane_buf_pkg::MODE_CHAIN), 40);

    // park words in lanes 2 and 5, then try to rewire
    write_ksize("write_k3", 32'd3, 1'b0);
    load_word(2, next_rand());
    load_word(5, next_rand());
    held    = all_empty;
    held[2] = 1'b0;
    held[5] = 1'b0;
    check_status("busy_status", held);
    write_ksize("busy_write", 32'd5, 1'b1);
    check_ksize("busy_ksize", lane_buf_pkg::MODE_K3);
    run_traffic("busy_drain", active_ports(lane_buf_pkg::MODE_K3), 0);
    check_status("drained_status", all_empty);
    write_ksize("retry_write", 32'd5, 1'b0);
    check_ksize("retry_ksize", lane_buf_pkg::MODE_K5);

    $display("Simulation PASSED");
    $finish;
  end

endmodule

//--- filelist.f
src/lane_buf_pkg.sv
src/lane_fifo.sv
src/lane_router.sv
src/kernel_cfg_apb.sv
src/output_lane_bank.sv
bench/tb_clock.sv
bench/output_lane_bank_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps -f filelist.f \
  --top-module output_lane_bank_tb -o sim &&
./obj_dir/sim || { echo "simulation did not pass"; exit 1; }
